/* common/conv_pkg.sv */
package conv_pkg;

    // Strip geometry
    localparam int img_w = 16;                          // Columns in the strip
    localparam int k_dim = 3;                           // Kernel side, also strip height
    localparam int col_w = 4;                           // Column index width
    localparam int row_w = 2;                           // Row index width

    // Kernel taps
    localparam int k_taps = k_dim * k_dim;              // 9 taps per window
    localparam int tap_w = 4;                           // Tap index width

    // Destination memory
    localparam int dst_depth = 32;                      // Result entries
    localparam int dst_aw = 5;                          // Result address width

    // Outputs per run for each stride
    localparam int outs_s1 = img_w - k_dim + 1;         // 14 windows at stride 1
    localparam int outs_s2 = (img_w - k_dim) / 2 + 1;   // 7 windows at stride 2

    // Payload types
    typedef logic [7:0] pixel_t;                        // Unsigned grey level
    typedef logic [7:0] coef_t;                         // Unsigned coefficient
    typedef logic [19:0] acc_t;                         // 9*255*255 fits in 20 bits
    typedef logic [1:0] stride_t;                       // Code 2 means stride 2

    // Sequencer states
    typedef enum logic [2:0] {
        idle    = 3'd0,                                 // Waiting for start
        fill    = 3'd1,                                 // Loading first three columns
        mac     = 3'd2,                                 // One tap per clock
        write   = 3'd3,                                 // Hand sum to writeback
        advance = 3'd4                                  // Shift in next column(s)
    } seq_state_t;

endpackage

/* hdl/line_store.sv */
`timescale 1ns/1ps

module line_store (
    input  logic                       clk,
    input  logic                       pix_we,     // Host write strobe
    input  logic [conv_pkg::row_w-1:0] pix_row,    // Row 0..2, row 3 ignored
    input  logic [conv_pkg::col_w-1:0] pix_col,
    input  conv_pkg::pixel_t           pix_data,
    input  logic [conv_pkg::col_w-1:0] col_addr,   // Column fetched by the sequencer
    output conv_pkg::pixel_t           col_pix0,   // Top row
    output conv_pkg::pixel_t           col_pix1,
    output conv_pkg::pixel_t           col_pix2    // Bottom row
);

    conv_pkg::pixel_t mem [conv_pkg::k_dim][conv_pkg::img_w];  // Row-major strip

    // Host write port
    always_ff @(posedge clk) begin
        if (pix_we && (int'(pix_row) < conv_pkg::k_dim)) begin  // Drop writes to row 3
            mem[pix_row][pix_col] <= pix_data;
        end
    end

    // One column out, all three rows at once
    assign col_pix0 = mem[0][col_addr];
    assign col_pix1 = mem[1][col_addr];
    assign col_pix2 = mem[2][col_addr];

endmodule

/* hdl/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
    parameter type word_t = logic [7:0],     // Stored payload
    parameter int  depth  = 16               // Number of words
) (
    input  logic                     clk,
    input  logic                     we,     // Write strobe
    input  logic [$clog2(depth)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output word_t                    rdata   // Combinational read
);

    word_t mem [depth];

    // Single write port, out-of-range addresses discarded
    always_ff @(posedge clk) begin
        if (we && (int'(waddr) < depth)) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port returns zero past the last word
    always_comb begin
        if (int'(raddr) < depth) begin
            rdata = mem[raddr];
        end else begin
            rdata = '0;
        end
    end

endmodule

/* convolve/conv_sequencer.sv */
`timescale 1ns/1ps

module conv_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,      // Sampled only in idle
    input  conv_pkg::stride_t          stride,
    output logic                       busy,       // High from fill to last write
    output logic                       done,       // One cycle after last write
    output logic [conv_pkg::col_w-1:0] col_addr,   // Line store column
    output logic                       shift,      // Window takes col_pix this edge
    output logic                       mac_clr,    // Load instead of add
    output logic                       mac_en,
    output logic                       wr_pulse,   // Sum ready for writeback
    output logic                       load_base,  // Writeback grabs dst_base
    output logic [conv_pkg::tap_w-1:0] tap         // Window tap and kernel address
);

    conv_pkg::seq_state_t       state;
    conv_pkg::stride_t          stride_q;   // Stride of the current run
    logic [conv_pkg::col_w-1:0] next_col;   // Next column to shift in
    logic [conv_pkg::tap_w-1:0] tap_cnt;
    logic [conv_pkg::col_w-1:0] outs_left;  // Windows still to write
    logic                       adv_cnt;    // Second advance cycle at stride 2
    logic                       stride2;
    logic                       accept;
    logic                       last_fill;
    logic                       last_tap;
    logic                       last_adv;
    logic                       last_out;

    assign stride2   = (stride_q == 2'd2);                       // Codes 0, 1, 3 run as stride 1
    assign accept    = (state == conv_pkg::idle) && start;
    assign last_fill = (next_col == conv_pkg::col_w'(conv_pkg::k_dim - 1));
    assign last_tap  = (tap_cnt == conv_pkg::tap_w'(conv_pkg::k_taps - 1));
    assign last_adv  = !stride2 || adv_cnt;                     // One or two shifts
    assign last_out  = (outs_left == conv_pkg::col_w'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= conv_pkg::idle;
            stride_q  <= '0;
            next_col  <= '0;
            tap_cnt   <= '0;
            outs_left <= '0;
            adv_cnt   <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;                                        // Pulse by default
            case (state)
                conv_pkg::idle: begin
                    if (start) begin
                        stride_q <= stride;
                        next_col <= '0;
                        tap_cnt  <= '0;
                        adv_cnt  <= 1'b0;
                        if (stride == 2'd2) begin
                            outs_left <= conv_pkg::col_w'(conv_pkg::outs_s2);
                        end else begin
                            outs_left <= conv_pkg::col_w'(conv_pkg::outs_s1);
                        end
                        state <= conv_pkg::fill;
                    end
                end
                conv_pkg::fill: begin
                    next_col <= next_col + 1'b1;                 // Columns 0, 1, 2
                    if (last_fill) begin
                        state <= conv_pkg::mac;
                    end
                end
                conv_pkg::mac: begin
                    if (last_tap) begin
                        tap_cnt <= '0;
                        state   <= conv_pkg::write;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                conv_pkg::write: begin
                    outs_left <= outs_left - 1'b1;
                    if (last_out) begin
                        done  <= 1'b1;                           // Busy drops with it
                        state <= conv_pkg::idle;
                    end else begin
                        state <= conv_pkg::advance;
                    end
                end
                conv_pkg::advance: begin
                    next_col <= next_col + 1'b1;
                    if (last_adv) begin
                        adv_cnt <= 1'b0;
                        state   <= conv_pkg::mac;
                    end else begin
                        adv_cnt <= 1'b1;
                    end
                end
                default: begin
                    state <= conv_pkg::idle;
                end
            endcase
        end
    end

    // Strobes decoded straight from state and counters
    assign busy      = (state != conv_pkg::idle);
    assign col_addr  = next_col;
    assign shift     = (state == conv_pkg::fill) || (state == conv_pkg::advance);
    assign mac_en    = (state == conv_pkg::mac);
    assign mac_clr   = mac_en && (tap_cnt == '0);                // First tap of a window
    assign tap       = tap_cnt;
    assign wr_pulse  = (state == conv_pkg::write);
    assign load_base = accept;

endmodule

/* convolve/conv_window.sv */
`timescale 1ns/1ps

module conv_window (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       shift,      // Move window one column
    input  conv_pkg::pixel_t           col_pix0,   // New column, top row
    input  conv_pkg::pixel_t           col_pix1,
    input  conv_pkg::pixel_t           col_pix2,
    input  logic [conv_pkg::tap_w-1:0] tap,        // Row tap/3, column tap%3
    input  conv_pkg::coef_t            coef,       // Kernel word for this tap
    input  logic                       mac_clr,
    input  logic                       mac_en,
    output conv_pkg::acc_t             acc
);

    conv_pkg::pixel_t win [conv_pkg::k_dim][conv_pkg::k_dim];  // [row][col], col 0 oldest
    conv_pkg::pixel_t sel_pix;
    conv_pkg::acc_t   product;

    // Window shift register
    always_ff @(posedge clk) begin
        if (shift) begin
            for (int r = 0; r < conv_pkg::k_dim; r++) begin
                win[r][0] <= win[r][1];                          // Drop the leftmost column
                win[r][1] <= win[r][2];
            end
            win[0][2] <= col_pix0;                               // New column on the right
            win[1][2] <= col_pix1;
            win[2][2] <= col_pix2;
        end
    end

    // Tap select
    always_comb begin
        case (tap)
            4'd0:    sel_pix = win[0][0];
            4'd1:    sel_pix = win[0][1];
            4'd2:    sel_pix = win[0][2];
            4'd3:    sel_pix = win[1][0];
            4'd4:    sel_pix = win[1][1];
            4'd5:    sel_pix = win[1][2];
            4'd6:    sel_pix = win[2][0];
            4'd7:    sel_pix = win[2][1];
            4'd8:    sel_pix = win[2][2];
            default: sel_pix = '0;                               // Taps 9..15 unused
        endcase
    end

    // 8x8 product widened before the add
    assign product = conv_pkg::acc_t'(sel_pix) * conv_pkg::acc_t'(coef);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (mac_en) begin
            if (mac_clr) begin
                acc <= product;                                  // Tap 0 starts a new sum
            end else begin
                acc <= acc + product;                            // No overflow at 20 bits
            end
        end
    end

endmodule

/* convolve/conv_writeback.sv */
`timescale 1ns/1ps

module conv_writeback (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_base,  // Run accepted
    input  logic [conv_pkg::dst_aw-1:0] dst_base,
    input  logic                        wr_pulse,   // acc holds a finished sum
    input  conv_pkg::acc_t              acc,
    output logic                        dst_we,     // One cycle after wr_pulse
    output logic [conv_pkg::dst_aw-1:0] dst_addr,
    output conv_pkg::acc_t              dst_wdata
);

    logic [conv_pkg::dst_aw-1:0] ptr;   // Address of the next result

    // Strobe and pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dst_we <= 1'b0;
            ptr    <= '0;
        end else begin
            dst_we <= wr_pulse;
            if (load_base) begin
                ptr <= dst_base;
            end else if (wr_pulse) begin
                ptr <= ptr + 1'b1;      // Wraps 31 to 0
            end
        end
    end

    // Write word and address travel together
    always_ff @(posedge clk) begin
        if (wr_pulse) begin
            dst_addr  <= ptr;
            dst_wdata <= acc;
        end
    end

endmodule

/* hdl/conv_top.sv */
`timescale 1ns/1ps

module conv_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pix_we,    // Strip load
    input  logic [conv_pkg::row_w-1:0]  pix_row,
    input  logic [conv_pkg::col_w-1:0]  pix_col,
    input  conv_pkg::pixel_t            pix_data,
    input  logic                        k_we,      // Kernel load
    input  logic [conv_pkg::tap_w-1:0]  k_addr,
    input  conv_pkg::coef_t             k_data,
    input  logic                        start,     // Run control
    input  conv_pkg::stride_t           stride,
    input  logic [conv_pkg::dst_aw-1:0] dst_base,
    input  logic [conv_pkg::dst_aw-1:0] rd_addr,   // Result readback
    output conv_pkg::acc_t              rd_data,
    output logic                        busy,
    output logic                        done
);

    logic [conv_pkg::col_w-1:0]  col_addr;
    logic                        shift;
    logic [conv_pkg::tap_w-1:0]  tap;
    logic                        mac_clr;
    logic                        mac_en;
    logic                        wr_pulse;
    logic                        load_base;
    conv_pkg::pixel_t            col_pix0;
    conv_pkg::pixel_t            col_pix1;
    conv_pkg::pixel_t            col_pix2;
    conv_pkg::coef_t             coef;
    conv_pkg::acc_t              acc;
    logic                        dst_we;
    logic [conv_pkg::dst_aw-1:0] dst_addr;
    conv_pkg::acc_t              dst_wdata;

    line_store u_line_store (
        .clk      (clk),
        .pix_we   (pix_we),
        .pix_row  (pix_row),
        .pix_col  (pix_col),
        .pix_data (pix_data),
        .col_addr (col_addr),
        .col_pix0 (col_pix0),
        .col_pix1 (col_pix1),
        .col_pix2 (col_pix2)
    );

    // Kernel coefficients, read by tap index
    word_ram #(
        .word_t (conv_pkg::coef_t),
        .depth  (conv_pkg::k_taps)
    ) u_kernel_ram (
        .clk   (clk),
        .we    (k_we),
        .waddr (k_addr),
        .wdata (k_data),
        .raddr (tap),
        .rdata (coef)
    );

    conv_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stride    (stride),
        .busy      (busy),
        .done      (done),
        .col_addr  (col_addr),
        .shift     (shift),
        .mac_clr   (mac_clr),
        .mac_en    (mac_en),
        .wr_pulse  (wr_pulse),
        .load_base (load_base),
        .tap       (tap)
    );

    conv_window u_window (
        .clk      (clk),
        .rst      (rst),
        .shift    (shift),
        .col_pix0 (col_pix0),
        .col_pix1 (col_pix1),
        .col_pix2 (col_pix2),
        .tap      (tap),
        .coef     (coef),
        .mac_clr  (mac_clr),
        .mac_en   (mac_en),
        .acc      (acc)
    );

    conv_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .load_base (load_base),
        .dst_base  (dst_base),
        .wr_pulse  (wr_pulse),
        .acc       (acc),
        .dst_we    (dst_we),
        .dst_addr  (dst_addr),
        .dst_wdata (dst_wdata)
    );

    // Results, read back by the host
    word_ram #(
        .word_t (conv_pkg::acc_t),
        .depth  (conv_pkg::dst_depth)
    ) u_dst_ram (
        .clk   (clk),
        .we    (dst_we),
        .waddr (dst_addr),
        .wdata (dst_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

/* testbench/conv_tb_tasks.svh */
// Stride rule: code 2 steps two columns, every other code steps one
function automatic int stride_of(input conv_pkg::stride_t code);
    return (code == 2'd2) ? 2 : 1;
endfunction

function automatic int num_outputs(input conv_pkg::stride_t code);
    return (16 - 3) / stride_of(code) + 1;                   // 14 or 7 windows
endfunction

// Expected sum of one window, row r and column c against kernel entry 3r+c
function automatic conv_pkg::acc_t ref_conv(
    input conv_pkg::pixel_t px [conv_pkg::k_dim][conv_pkg::img_w],
    input conv_pkg::coef_t  kc [conv_pkg::k_taps],
    input int               s,
    input int               idx
);
    conv_pkg::acc_t sum;
    sum = '0;
    for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
            sum += conv_pkg::acc_t'(px[r][idx * s + c]) * conv_pkg::acc_t'(kc[3 * r + c]);
        end
    end
    return sum;
endfunction

task automatic check_acc(input conv_pkg::acc_t got, input conv_pkg::acc_t exp, input string what);
    if (got !== exp) begin
        $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        errors++;
    end
endtask

// Random strip and kernel, host copies kept alongside
task automatic load_data();
    for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            pix_we      = 1'b1;
            pix_row     = conv_pkg::row_w'(r);
            pix_col     = conv_pkg::col_w'(c);
            pix_data    = conv_pkg::pixel_t'($urandom);
            strip[r][c] = pix_data;
        end
    end
    for (int k = 0; k < 9; k++) begin
        @(negedge clk);
        pix_we  = 1'b0;
        k_we    = 1'b1;
        k_addr  = conv_pkg::tap_w'(k);
        k_data  = conv_pkg::coef_t'($urandom);
        kern[k] = k_data;
    end
    @(negedge clk);
    k_we = 1'b0;
endtask

task automatic start_run(input conv_pkg::stride_t code, input int base);
    @(negedge clk);
    start    = 1'b1;
    stride   = code;
    dst_base = conv_pkg::dst_aw'(base);
    @(negedge clk);
    start = 1'b0;                                             // Single-cycle pulse
endtask

task automatic wait_done(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < 400) begin                         // Longest run is about 160 cycles
        @(negedge clk);
        ok = done;
        cycles++;
    end
    if (!ok) begin
        $display("done did not pulse within 400 cycles, run timed out at %0t", $time);
        timeouts++;
    end
endtask

task automatic read_word(input int addr, output conv_pkg::acc_t value);
    @(negedge clk);
    rd_addr = conv_pkg::dst_aw'(addr);
    @(posedge clk);                                           // Combinational read settled
    value = rd_data;
endtask

// Outputs first..first+count-1 of a run based at base, wrapping at 32
task automatic check_results(input conv_pkg::stride_t code, input int base, input int first,
                             input int count);
    conv_pkg::acc_t got;
    int             addr;
    for (int i = first; i < first + count; i++) begin
        addr = (base + i) % 32;
        read_word(addr, got);
        check_acc(got, ref_conv(strip, kern, stride_of(code), i), $sformatf("word %0d", addr));
    end
endtask

/* testbench/conv_tb.sv */
`timescale 1ns/1ps

module conv_tb;

    logic                        clk;
    logic                        rst;
    logic                        pix_we;
    logic [conv_pkg::row_w-1:0]  pix_row;
    logic [conv_pkg::col_w-1:0]  pix_col;
    conv_pkg::pixel_t            pix_data;
    logic                        k_we;
    logic [conv_pkg::tap_w-1:0]  k_addr;
    conv_pkg::coef_t             k_data;
    logic                        start;
    conv_pkg::stride_t           stride;
    logic [conv_pkg::dst_aw-1:0] dst_base;
    logic [conv_pkg::dst_aw-1:0] rd_addr;
    conv_pkg::acc_t              rd_data;
    logic                        busy;
    logic                        done;

    conv_pkg::pixel_t strip [conv_pkg::k_dim][conv_pkg::img_w];  // Host copy of the strip
    conv_pkg::coef_t  kern [conv_pkg::k_taps];                   // Host copy of the kernel
    int errors;
    int timeouts;
    int tests_run;
    int tests_failed;
    int err_mark;                                                // Errors before current test
    int done_count;                                              // Done pulses seen
    int done_mark;
    bit ok;

    conv_top u_conv_top (.*);

    `include "conv_tb_tasks.svh"

    task automatic end_test(input string name, input bit finished);
        tests_run++;
        if (!finished || errors != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        err_mark = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                                  // 20 ns period
    end

    // Done must be a lone pulse with busy already low
    always @(negedge clk) begin
        if (!rst && done) begin
            done_count++;
            check_flag(busy, 1'b0, "busy during done");
        end
    end

    initial begin
        void'($urandom(32'hc638_19d6));
        rst          = 1'b1;
        pix_we       = 1'b0;
        pix_row      = '0;
        pix_col      = '0;
        pix_data     = '0;
        k_we         = 1'b0;
        k_addr       = '0;
        k_data       = '0;
        start        = 1'b0;
        stride       = 2'd1;
        dst_base     = '0;
        rd_addr      = '0;
        errors       = 0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        done_count   = 0;
        repeat (10) @(posedge clk);                              // Ten reset cycles
        @(negedge clk);
        rst = 1'b0;

        load_data();
        start_run(2'd1, 0);
        wait_done(ok);
        check_results(2'd1, 0, 0, num_outputs(2'd1));
        end_test("stride 1", ok);

        start_run(2'd2, 0);                                      // Same strip and kernel
        wait_done(ok);
        check_results(2'd2, 0, 0, num_outputs(2'd2));
        check_results(2'd1, 0, 7, 7);                            // Left over from stride 1
        end_test("stride 2", ok);

        load_data();
        start_run(2'd1, 28);
        wait_done(ok);
        check_results(2'd1, 28, 0, num_outputs(2'd1));           // 28..31 then 0..9
        end_test("address wrap", ok);

        done_mark = done_count;
        start_run(2'd1, 0);
        repeat (20) @(negedge clk);
        start    = 1'b1;                                         // Second start mid-run
        stride   = 2'd2;
        dst_base = 5'd16;
        @(negedge clk);
        start = 1'b0;
        wait_done(ok);
        repeat (100) @(negedge clk);                             // Room for a stray second run
        check_flag((done_count - done_mark) == 1, 1'b1, "single done pulse");
        check_results(2'd1, 0, 0, num_outputs(2'd1));
        start_run(2'd3, 16);                                     // Code 3 runs at stride 1
        wait_done(ok);
        check_results(2'd3, 16, 0, 14);
        end_test("start while busy", ok);

        load_data();
        start_run(2'd1, 0);
        repeat (40) @(negedge clk);
        done_mark = done_count;
        rst = 1'b1;                                              // Abort the run
        repeat (3) @(negedge clk);
        check_flag(busy, 1'b0, "busy in reset");
        check_flag(done, 1'b0, "done in reset");
        rst = 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        repeat (200) @(negedge clk);                             // Longer than the rest of the run
        check_flag(done_count == done_mark, 1'b1, "no done from aborted run");
        start_run(2'd2, 0);
        wait_done(ok);
        check_results(2'd2, 0, 0, num_outputs(2'd2));
        end_test("reset mid-run", ok);

        $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
common/conv_pkg.sv
hdl/line_store.sv
hdl/word_ram.sv
convolve/conv_sequencer.sv
convolve/conv_window.sv
convolve/conv_writeback.sv
hdl/conv_top.sv
testbench/conv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module conv_tb -o conv_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/conv_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
